//--- src/board_pkg.sv
package board_pkg;

    // ----------------------------------------------------------------------
    // Data widths

    parameter int w_mic       = 24;  // INMP441 sample width
    parameter int w_seg       = 8;   // Seven segments plus point
    parameter int w_tm_digit  = 8;   // TM1638 display digits
    parameter int w_tm_led    = 8;   // TM1638 red LEDs
    parameter int w_digit_idx = 3;   // Index into the eight digits

    // ----------------------------------------------------------------------
    // TM1638 command bytes

    parameter logic [7:0] tm_cmd_data = 8'h40;  // Write data, auto increment
    parameter logic [7:0] tm_cmd_addr = 8'hc0;  // Start at address 0
    parameter logic [7:0] tm_cmd_disp = 8'h8f;  // Display on, pulse width 14/16

    // ----------------------------------------------------------------------
    // I2S framing

    parameter int i2s_slot_bits = 32;  // Bit clocks per channel slot

endpackage

//--- src/slow_clk_gen.sv
`timescale 1ns/10ps

module slow_clk_gen
#(
    parameter int clk_mhz     = 27,
    parameter int slow_clk_hz = 1
)
(
    input  logic clk,
    input  logic arst_n,
    output logic slow_clk,
    output logic slow_tick
);

    localparam int half_period = clk_mhz * 1000000 / (2 * slow_clk_hz);
    localparam int w_cnt       = half_period > 1 ? $clog2(half_period) : 1;

    logic [w_cnt - 1:0] cnt;
    logic               slow_clk_d;

    // Half period down-counter, slow_clk flips on every reload
    always_ff @(posedge clk or negedge arst_n)
        if (!arst_n)
        begin
            cnt      <= w_cnt'(half_period - 1);
            slow_clk <= 1'b0;
        end
        else if (cnt == '0)
        begin
            cnt      <= w_cnt'(half_period - 1);
            slow_clk <= ~slow_clk;
        end
        else
            cnt <= cnt - 1'b1;

    // Rising edge detector, tick lands one clock after the edge
    always_ff @(posedge clk or negedge arst_n)
        if (!arst_n)
        begin
            slow_clk_d <= 1'b0;
            slow_tick  <= 1'b0;
        end
        else
        begin
            slow_clk_d <= slow_clk;
            slow_tick  <= slow_clk & ~slow_clk_d;
        end

    a_tick_single : assert property (
        @(posedge clk) disable iff (!arst_n) slow_tick |=> !slow_tick);

endmodule

//--- src/inmp441_mic_i2s_receiver.sv
`timescale 1ns/10ps

module inmp441_mic_i2s_receiver import board_pkg::*;
#(
    parameter int sck_div = 4
)
(
    input  logic               clk,
    input  logic               arst_n,
    input  logic               sd,
    output logic               sck,
    output logic               ws,
    output logic               lr,
    output logic [w_mic - 1:0] value
);

    localparam int w_div  = sck_div > 1 ? $clog2(sck_div) : 1;
    localparam int w_slot = $clog2(i2s_slot_bits);

    logic [w_div  - 1:0] div_cnt;
    logic [w_slot - 1:0] slot_cnt;
    logic [w_mic  - 1:0] shift;
    logic                half_done;
    logic                sck_rise;
    logic                sck_fall;
    logic                done;

    assign lr = 1'b0;  // L/R pin low selects the left slot

    // ----------------------------------------------------------------------
    // Bit clock and word select

    assign half_done = div_cnt == w_div'(sck_div - 1);
    assign sck_rise  = half_done & ~sck;
    assign sck_fall  = half_done &  sck;

    always_ff @(posedge clk or negedge arst_n)
        if (!arst_n)
        begin
            div_cnt  <= '0;
            sck      <= 1'b0;
            ws       <= 1'b0;
            slot_cnt <= '0;
        end
        else
        begin
            div_cnt <= half_done ? '0 : div_cnt + 1'b1;

            if (half_done)
                sck <= ~sck;

            if (sck_fall)
            begin
                if (slot_cnt == w_slot'(i2s_slot_bits - 1))
                begin
                    slot_cnt <= '0;
                    ws       <= ~ws;          // Changes with the falling sck
                end
                else
                    slot_cnt <= slot_cnt + 1'b1;
            end
        end

    // ----------------------------------------------------------------------
    // Sample capture, slot bit 0 is the I2S delay bit

    always_ff @(posedge clk)
        if (sck_rise && !ws && slot_cnt >= 1 && slot_cnt <= w_slot'(w_mic))
            shift <= { shift [w_mic - 2:0], sd };  // MSB arrives first

    always_ff @(posedge clk or negedge arst_n)
        if (!arst_n)
        begin
            done  <= 1'b0;
            value <= '0;
        end
        else
        begin
            done <= sck_rise & ~ws & (slot_cnt == w_slot'(w_mic));

            if (done)
                value <= shift;
        end

    a_ws_on_low_sck : assert property (
        @(posedge clk) disable iff (!arst_n) $changed(ws) |-> !sck);

endmodule

//--- src/lab_top.sv
`timescale 1ns/10ps

module lab_top import board_pkg::*;
#(
    parameter int w_key = 2,
    parameter int w_led = 6
)
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    slow_tick,
    input  logic [w_key      - 1:0] key,
    input  logic [w_mic      - 1:0] mic,
    output logic [w_led      - 1:0] led,
    output logic [w_seg      - 1:0] abcdefgh,
    output logic [w_tm_digit - 1:0] digit,
    output logic [w_tm_led   - 1:0] tm_led
);

    logic [w_digit_idx - 1:0] scan_idx;
    logic [w_tm_led    - 1:0] tick_cnt;
    logic [              3:0] nibble;

    // Hex digit to segments, a in the MSB and the point off
    function automatic logic [w_seg - 1:0] hex_to_seg(input logic [3:0] nib);
        case (nib)
            4'h0: return 8'b1111_1100;
            4'h1: return 8'b0110_0000;
            4'h2: return 8'b1101_1010;
            4'h3: return 8'b1111_0010;
            4'h4: return 8'b0110_0110;
            4'h5: return 8'b1011_0110;
            4'h6: return 8'b1011_1110;
            4'h7: return 8'b1110_0000;
            4'h8: return 8'b1111_1110;
            4'h9: return 8'b1111_0110;
            4'ha: return 8'b1110_1110;
            4'hb: return 8'b0011_1110;
            4'hc: return 8'b1001_1100;
            4'hd: return 8'b0111_1010;
            4'he: return 8'b1001_1110;
            default: return 8'b1000_1110;
        endcase
    endfunction

    // ----------------------------------------------------------------------
    // Tick counter, key 0 holds it at zero

    always_ff @(posedge clk or negedge arst_n)
        if (!arst_n)
            tick_cnt <= '0;
        else if (key [0])
            tick_cnt <= '0;
        else if (slow_tick)
            tick_cnt <= tick_cnt + 1'b1;

    assign tm_led = tick_cnt;  // LED i sits over digit i

    // ----------------------------------------------------------------------
    // Digit scan

    always_comb
        case (scan_idx)
            w_digit_idx'(6): nibble = tick_cnt [7:4];
            w_digit_idx'(7): nibble = tick_cnt [3:0];
            default:         nibble = mic [w_mic - 1 - 4 * scan_idx -: 4];
        endcase

    always_ff @(posedge clk or negedge arst_n)
        if (!arst_n)
        begin
            scan_idx <= '0;
            digit    <= w_tm_digit'(1);
            abcdefgh <= '0;
        end
        else
        begin
            scan_idx <= scan_idx + 1'b1;            // One digit per clock
            digit    <= w_tm_digit'(1) << scan_idx;
            abcdefgh <= hex_to_seg(nibble);
        end

    // Top microphone bits to the board LEDs
    always_ff @(posedge clk or negedge arst_n)
        if (!arst_n)
            led <= '0;
        else
            led <= mic [w_mic - 1 -: w_led];

    a_digit_onehot : assert property (
        @(posedge clk) disable iff (!arst_n) $onehot(digit));

endmodule

//--- src/tm1638_board_controller.sv
`timescale 1ns/10ps

module tm1638_board_controller import board_pkg::*;
#(
    parameter int tm_div = 16
)
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic [w_seg      - 1:0] hgfedcba,
    input  logic [w_tm_digit - 1:0] digit,
    input  logic [w_tm_led   - 1:0] ledr,
    output logic                    sio_clk,
    output logic                    sio_stb,
    output logic                    sio_data
);

    localparam int w_div = tm_div > 1 ? $clog2(tm_div) : 1;

    typedef enum logic [1:0]
    {
        st_gap,   // Strobe high between bursts
        st_lead,  // Strobe low, serial clock still high
        st_low,   // Serial clock low, data changes here
        st_high   // Serial clock high, TM1638 samples
    } state_t;

    state_t              state;
    logic [w_div  - 1:0] div_cnt;
    logic                tick;
    logic [         1:0] burst;
    logic [         4:0] byte_cnt;
    logic [         4:0] next_idx;
    logic [         4:0] last_byte;
    logic [         2:0] bit_cnt;
    logic [w_seg  - 1:0] cur_byte;
    logic [w_seg  - 1:0] next_byte;
    logic [w_tm_led - 1:0] led_lat;
    logic [w_seg  - 1:0] seg_buf [w_tm_digit];

    // ----------------------------------------------------------------------
    // Catch the multiplexed pattern of each digit

    always_ff @(posedge clk)
        for (int i = 0; i < w_tm_digit; i++)
            if (digit [i])
                seg_buf [i] <= hgfedcba;

    // ----------------------------------------------------------------------
    // Byte selection for the current burst

    assign next_idx  = (state == st_lead) ? 5'd0 : byte_cnt + 1'b1;
    assign last_byte = (burst == 2'd1) ? 5'd16 : 5'd0;

    always_comb
    begin
        logic [3:0]               j;
        logic [w_digit_idx - 1:0] d;

        j = 4'(next_idx - 1'b1);
        d = j [3:1];

        case (burst)
            2'd0:    next_byte = tm_cmd_data;
            2'd1:
                if (next_idx == 5'd0)
                    next_byte = tm_cmd_addr;
                else if (!j [0])
                    next_byte = seg_buf [d];                   // Segment byte
                else
                    next_byte = { {(w_seg - 1){1'b0}}, led_lat [d] };  // LED byte
            default: next_byte = tm_cmd_disp;
        endcase
    end

    // ----------------------------------------------------------------------
    // Half bit pacing and frame sequencer

    assign tick = div_cnt == w_div'(tm_div - 1);

    always_ff @(posedge clk or negedge arst_n)
        if (!arst_n)
            div_cnt <= '0;
        else
            div_cnt <= tick ? '0 : div_cnt + 1'b1;

    always_ff @(posedge clk or negedge arst_n)
        if (!arst_n)
        begin
            state    <= st_gap;
            burst    <= 2'd0;
            byte_cnt <= '0;
            bit_cnt  <= '0;
            sio_clk  <= 1'b1;
            sio_stb  <= 1'b1;
            sio_data <= 1'b0;
        end
        else if (tick)
        begin
            case (state)
                st_gap:
                begin
                    sio_stb <= 1'b0;
                    state   <= st_lead;
                end
                st_lead:
                begin
                    byte_cnt <= '0;
                    bit_cnt  <= '0;
                    sio_clk  <= 1'b0;
                    sio_data <= next_byte [0];   // LSB goes first
                    state    <= st_low;
                end
                st_low:
                begin
                    sio_clk <= 1'b1;
                    state   <= st_high;
                end
                default:
                    if (bit_cnt != 3'd7)
                    begin
                        bit_cnt  <= bit_cnt + 1'b1;
                        sio_clk  <= 1'b0;
                        sio_data <= cur_byte [bit_cnt + 1'b1];
                        state    <= st_low;
                    end
                    else if (byte_cnt != last_byte)
                    begin
                        byte_cnt <= byte_cnt + 1'b1;
                        bit_cnt  <= '0;
                        sio_clk  <= 1'b0;
                        sio_data <= next_byte [0];
                        state    <= st_low;
                    end
                    else
                    begin
                        sio_stb <= 1'b1;                 // End of burst
                        burst   <= (burst == 2'd2) ? 2'd0 : burst + 1'b1;
                        state   <= st_gap;
                    end
            endcase
        end

    // Byte and LED snapshots, no reset needed before first use
    always_ff @(posedge clk)
        if (tick)
        begin
            if (state == st_gap && burst == 2'd0)
                led_lat <= ledr;                         // Once per frame

            if (state == st_lead || (state == st_high && bit_cnt == 3'd7
                                     && byte_cnt != last_byte))
                cur_byte <= next_byte;
        end

    a_data_stable_high : assert property (
        @(posedge clk) disable iff (!arst_n)
        (sio_clk && $past(sio_clk)) |-> $stable(sio_data));

endmodule

//--- src/board_specific_top.sv
`timescale 1ns/10ps

module board_specific_top import board_pkg::*;
#(
    parameter int clk_mhz     = 27,
    parameter int slow_clk_hz = 2,
    parameter int sck_div     = 4,
    parameter int tm_div      = 16,
    parameter int w_key       = 2,
    parameter int w_led       = 6
)
(
    input  logic               clk,
    input  logic               arst_n,
    input  logic [w_key - 1:0] key_n,
    input  logic               mic_sd,
    output logic [w_led - 1:0] led_n,
    output logic               mic_sck,
    output logic               mic_ws,
    output logic               mic_lr,
    output logic               tm_sio_clk,
    output logic               tm_sio_stb,
    output logic               tm_sio_data
);

    logic [w_key      - 1:0] key;
    logic [w_led      - 1:0] led;
    logic [w_mic      - 1:0] mic;
    logic [w_seg      - 1:0] abcdefgh;
    logic [w_seg      - 1:0] hgfedcba;
    logic [w_tm_digit - 1:0] digit;
    logic [w_tm_led   - 1:0] tm_led;
    logic                    slow_tick;

    assign key   = ~key_n;  // Keys pull low when pressed
    assign led_n = ~led;    // LEDs light on a low pin

    // ----------------------------------------------------------------------

    slow_clk_gen
    #(
        .clk_mhz     ( clk_mhz     ),
        .slow_clk_hz ( slow_clk_hz )
    )
    i_slow_clk_gen
    (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .slow_clk  (           ),
        .slow_tick ( slow_tick )
    );

    inmp441_mic_i2s_receiver #( .sck_div ( sck_div ) ) i_microphone
    (
        .clk    ( clk     ),
        .arst_n ( arst_n  ),
        .sd     ( mic_sd  ),
        .sck    ( mic_sck ),
        .ws     ( mic_ws  ),
        .lr     ( mic_lr  ),
        .value  ( mic     )
    );

    lab_top #( .w_key ( w_key ), .w_led ( w_led ) ) i_lab_top
    (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .slow_tick ( slow_tick ),
        .key       ( key       ),
        .mic       ( mic       ),
        .led       ( led       ),
        .abcdefgh  ( abcdefgh  ),
        .digit     ( digit     ),
        .tm_led    ( tm_led    )
    );

    // ----------------------------------------------------------------------
    // TM1638 wants segment a in bit 0

    for (genvar i = 0; i < w_seg; i++)
    begin : g_seg_rev
        assign hgfedcba [i] = abcdefgh [w_seg - 1 - i];
    end

    tm1638_board_controller #( .tm_div ( tm_div ) ) i_tm1638
    (
        .clk      ( clk         ),
        .arst_n   ( arst_n      ),
        .hgfedcba ( hgfedcba    ),
        .digit    ( digit       ),
        .ledr     ( tm_led      ),
        .sio_clk  ( tm_sio_clk  ),
        .sio_stb  ( tm_sio_stb  ),
        .sio_data ( tm_sio_data )
    );

endmodule

//--- tb/tb_tm1638_checker.sv
`timescale 1ns/10ps

module tb_tm1638_checker
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic [1:0]  key_n,
    input  logic [5:0]  led_n,
    input  logic        mic_sck,
    input  logic        mic_ws,
    input  logic        mic_lr,
    input  logic        sio_clk,
    input  logic        sio_stb,
    input  logic        sio_data,
    input  logic        check,
    input  int          test_no,
    input  logic [47:0] exp_seg,
    input  logic [5:0]  exp_led_n,
    input  logic        exp_clear,
    output int          frames,
    output int          errors,
    output int          tests
);

    logic [7:0]  bytes [17];
    logic [7:0]  shreg;
    logic [7:0]  seg [8];
    logic [7:0]  leds;
    logic [47:0] last_seg;
    logic [7:0]  last_cnt;
    logic [7:0]  last_leds;
    logic        clk_d;
    logic        stb_d;
    logic        arst_n_d;
    logic        clear_seen;
    logic        last_clear;
    logic        held_all;
    int          nbits;
    int          nbytes;
    int          phase;
    int          test_err;

    initial
    begin
        frames     = 0;
        errors     = 0;
        tests      = 0;
        nbits      = 0;
        nbytes     = 0;
        phase      = 0;
        test_err   = 0;
        clk_d      = 1'b1;
        stb_d      = 1'b1;
        arst_n_d   = 1'b1;
        clear_seen = 1'b1;
        last_clear = 1'b1;
        held_all   = 1'b1;
        last_cnt   = '0;
        last_leds  = '0;
        last_seg   = '0;
    end

    task automatic report_error(input string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
        errors++;
        test_err++;
    endtask

    // Segment pattern back to its hex value, 16 if it is no digit
    function automatic int nib_of(input logic [7:0] p);
        logic [7:0] t [16];
        t = '{8'h3f, 8'h06, 8'h5b, 8'h4f, 8'h66, 8'h6d, 8'h7d, 8'h07,
              8'h7f, 8'h6f, 8'h77, 8'h7c, 8'h39, 8'h5e, 8'h79, 8'h71};
        for (int i = 0; i < 16; i++)
            if (t [i] == p)
                return i;
        return 16;
    endfunction

    // ------------------------------------------------------------------
    // Frame checks, run after the display command burst

    task automatic frame_done();
        int         hi;
        int         lo;
        logic [7:0] cnt;
        frames++;
        hi = nib_of(seg [6]);
        lo = nib_of(seg [7]);
        if (hi > 15 || lo > 15)
            report_error("counter digits are no hex pattern");
        // High digit leaves the scan two bytes before the low one
        cnt = 8'((hi << 4) | lo);
        if (8'(cnt - leds) > 8'd31)
            cnt = 8'(((hi + 1) << 4) | lo);
        if (!clear_seen && 8'(cnt - leds) > 8'd31)
            report_error("counter digits disagree with the TM1638 LEDs");
        if (held_all && (cnt != 8'd0 || leds != 8'd0))
            report_error("counter not zero in a frame with key 0 held");
        if (frames == 1)
            for (int d = 0; d < 8; d++)
                if (seg [d] != 8'h3f || leds != 8'h00)
                    report_error("first frame is not all zero");
        if (!clear_seen && !last_clear && 8'(cnt - last_cnt) > 8'd63)
            report_error("tick counter went backwards");
        last_seg   = {seg [0], seg [1], seg [2], seg [3], seg [4], seg [5]};
        last_cnt   = cnt;
        last_leds  = leds;
        last_clear = clear_seen;
        clear_seen = !key_n [0];
        held_all   = !key_n [0];
    endtask

    task automatic burst_done();
        if (phase == 0)
        begin
            if (nbytes != 1 || bytes [0] != 8'h40)
                report_error("data command burst is wrong");
            phase = 1;
        end
        else if (phase == 1)
        begin
            if (nbytes != 17 || bytes [0] != 8'hc0)
                report_error("address and data burst is wrong");
            for (int d = 0; d < 8; d++)
            begin
                seg [d]  = bytes [1 + 2 * d];
                leds [d] = bytes [2 + 2 * d][0];
                if (bytes [2 + 2 * d][7:1] != '0)
                    report_error("LED byte has upper bits set");
            end
            phase = 2;
        end
        else
        begin
            if (nbytes != 1 || bytes [0] != 8'h8f)
                report_error("display command burst is wrong");
            phase = 0;
            frame_done();
        end
        nbytes = 0;
        nbits  = 0;
    endtask

    always @(posedge clk)
    begin
        if (!arst_n)
        begin
            if (!arst_n_d && (led_n !== 6'h3f || sio_stb !== 1'b1 || sio_clk !== 1'b1
                              || sio_data !== 1'b0 || mic_sck !== 1'b0
                              || mic_ws !== 1'b0))
                report_error("outputs are wrong during reset");
        end
        else
        begin
            if (!key_n [0])
                clear_seen = 1'b1;
            else
                held_all = 1'b0;
            if (!sio_stb && sio_clk && !clk_d)
            begin
                shreg = {sio_data, shreg [7:1]};     // LSB first
                nbits++;
                if (nbits == 8)
                begin
                    if (nbytes < 17)
                        bytes [nbytes] = shreg;
                    nbytes++;
                    nbits = 0;
                end
            end
            if (sio_stb && !stb_d)
                burst_done();
            if (check)
            begin
                if (last_seg != exp_seg)
                    report_error($sformatf("digits %h, expected %h", last_seg, exp_seg));
                if (led_n != exp_led_n)
                    report_error($sformatf("led_n %h, expected %h", led_n, exp_led_n));
                if (mic_lr !== 1'b0)
                    report_error("mic_lr is not held low");
                if (exp_clear && (last_cnt != 0 || last_leds != 0))
                    report_error("counter not zero while key 0 is held");
                $display("Test %0d %s", test_no, test_err == 0 ? "ok" : "mismatch");
                tests++;
                test_err = 0;
            end
        end
        clk_d    = sio_clk;
        stb_d    = sio_stb;
        arst_n_d = arst_n;
    end

endmodule

//--- tb/tb_board_top.sv
`timescale 1ns/10ps

module tb_board_top;

    localparam int n_fixed = 6;
    localparam int n_rows  = 10;

    logic        clk;
    logic        arst_n;
    logic [1:0]  key_n;
    logic        mic_sd;
    logic [5:0]  led_n;
    logic        mic_sck;
    logic        mic_ws;
    logic        mic_lr;
    logic        tm_sio_clk;
    logic        tm_sio_stb;
    logic        tm_sio_data;

    logic        check;
    int          test_no;
    logic [47:0] exp_seg;
    logic [5:0]  exp_led_n;
    logic        exp_clear;
    int          frames;
    int          errors;
    int          tests;

    logic [23:0] cur_sample;
    logic        mic_sck_d;
    logic        mic_ws_d;
    int          bit_idx;

    // Stimulus table, expected columns are filled in by build_table
    logic [23:0] row_sample [n_rows];
    logic        row_key    [n_rows];
    logic [47:0] row_seg    [n_rows];
    logic [5:0]  row_led_n  [n_rows];

    board_specific_top
    #(
        .clk_mhz     ( 1     ),
        .slow_clk_hz ( 25000 ),
        .sck_div     ( 2     ),
        .tm_div      ( 2     )
    )
    i_dut
    (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .key_n       ( key_n       ),
        .mic_sd      ( mic_sd      ),
        .led_n       ( led_n       ),
        .mic_sck     ( mic_sck     ),
        .mic_ws      ( mic_ws      ),
        .mic_lr      ( mic_lr      ),
        .tm_sio_clk  ( tm_sio_clk  ),
        .tm_sio_stb  ( tm_sio_stb  ),
        .tm_sio_data ( tm_sio_data )
    );

    tb_tm1638_checker i_checker
    (
        .clk       ( clk         ),
        .arst_n    ( arst_n      ),
        .key_n     ( key_n       ),
        .led_n     ( led_n       ),
        .mic_sck   ( mic_sck     ),
        .mic_ws    ( mic_ws      ),
        .mic_lr    ( mic_lr      ),
        .sio_clk   ( tm_sio_clk  ),
        .sio_stb   ( tm_sio_stb  ),
        .sio_data  ( tm_sio_data ),
        .check     ( check       ),
        .test_no   ( test_no     ),
        .exp_seg   ( exp_seg     ),
        .exp_led_n ( exp_led_n   ),
        .exp_clear ( exp_clear   ),
        .frames    ( frames      ),
        .errors    ( errors      ),
        .tests     ( tests       )
    );

    always #2 clk = ~clk;  // 4 ns period

    // Seven segment pattern with segment a in bit 0
    function automatic logic [7:0] seg_pattern(input logic [3:0] nib);
        logic [7:0] p [16];
        p = '{8'h3f, 8'h06, 8'h5b, 8'h4f, 8'h66, 8'h6d, 8'h7d, 8'h07,
              8'h7f, 8'h6f, 8'h77, 8'h7c, 8'h39, 8'h5e, 8'h79, 8'h71};
        return p [nib];
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic build_table();
        logic [31:0] seed;
        seed = 32'hdfc3;
        row_sample = '{24'h000000, 24'h123456, 24'h89abcd, 24'hfedcba, 24'h0f0f0f,
                       24'hffffff, 24'h0, 24'h0, 24'h0, 24'h0};
        row_key    = '{1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
        for (int r = n_fixed; r < n_rows; r++)
        begin
            seed           = lcg_next(seed);
            row_sample [r] = seed [31:8];           // Upper bits are the better ones
        end
        for (int r = 0; r < n_rows; r++)
        begin
            for (int d = 0; d < 6; d++)
                row_seg [r][47 - 8 * d -: 8] = seg_pattern(row_sample [r][23 - 4 * d -: 4]);
            row_led_n [r] = ~row_sample [r][23:18];
        end
    endtask

    // ------------------------------------------------------------------
    // Microphone model, follows the slot rule seen from the pins

    always @(negedge clk)
    begin
        if (mic_sck_d && !mic_sck)
        begin
            bit_idx = (mic_ws != mic_ws_d) ? 0 : bit_idx + 1;
            if (!mic_ws && bit_idx >= 1 && bit_idx <= 24)
                mic_sd = cur_sample [24 - bit_idx];  // MSB after the delay bit
            else
                mic_sd = 1'b0;
        end
        mic_sck_d = mic_sck;
        mic_ws_d  = mic_ws;
    end

    task automatic wait_ws_edges(input int n);
        int   seen;
        int   cycles;
        logic prev;
        seen   = 0;
        cycles = 0;
        prev   = mic_ws;
        while (seen < n && cycles < 2000)
        begin
            @(negedge clk);
            cycles++;
            if (mic_ws != prev)
                seen++;
            prev = mic_ws;
        end
        if (seen < n)
        begin
            $display("Timeout: the I2S word select stopped toggling");
            $display("Simulation FAILED");
            $finish;
        end
    endtask

    task automatic wait_frames(input int n);
        int start;
        int cycles;
        start  = frames;
        cycles = 0;
        while (frames < start + n && cycles < 4000)
        begin
            @(negedge clk);
            cycles++;
        end
        if (frames < start + n)
        begin
            $display("Timeout: no complete TM1638 frame arrived");
            $display("Simulation FAILED");
            $finish;
        end
    endtask

    initial
    begin
        clk        = 1'b0;
        arst_n     = 1'b0;
        key_n      = 2'b10;                        // Key 0 held from the start
        mic_sd     = 1'b0;
        check      = 1'b0;
        test_no    = 0;
        exp_seg    = '0;
        exp_led_n  = '1;
        exp_clear  = 1'b0;
        cur_sample = '0;
        mic_sck_d  = 1'b0;
        mic_ws_d   = 1'b0;
        bit_idx    = 0;
        build_table();
        repeat (5) @(negedge clk);
        arst_n = 1'b1;

        for (int r = 0; r < n_rows; r++)
        begin
            @(negedge clk);
            cur_sample = row_sample [r];
            key_n [0]  = ~row_key [r];
            exp_seg    = row_seg [r];
            exp_led_n  = row_led_n [r];
            exp_clear  = row_key [r];
            wait_ws_edges(4);
            wait_frames(2);
            test_no = r;
            check   = 1'b1;
            @(negedge clk);
            check   = 1'b0;
        end

        @(negedge clk);
        $display("Tests %0d, frames %0d, errors %0d", tests, frames, errors);
        if (errors == 0 && tests == n_rows)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- verilog.f
src/board_pkg.sv
src/slow_clk_gen.sv
src/inmp441_mic_i2s_receiver.sv
src/lab_top.sv
src/tm1638_board_controller.sv
src/board_specific_top.sv
tb/tb_tm1638_checker.sv
tb/tb_board_top.sv

//--- run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_board_top -f verilog.f -o tb_sim

output=$(./obj_dir/tb_sim)
echo "$output"

echo "$output" | grep -q "^Simulation PASSED$"
